// File: ovcam_trace.txt
// rgb565 camera pixels for the first frame, sent high byte first
// one image row per line, columns 0 to 7 from left to right, rows 0 to 5 top down
f800 07e0 001f ffff 0000 8410 c618 4208
a145 3ce7 9b2d 52aa e71c 18c3 6d5b f0f0
0f0f 7bef b5b6 2965 dead beef 1234 5678
9abc def0 4c2e 83d1 37a9 e2f4 5b06 c87d
0a5f f5a0 6e93 1b4c d2e7 7f08 a6b9 3c1d
8888 4444 2222 1111 eeee dddd bbbb 7777

// File: project.f
ovcam_pkg.sv
ov7670_capture.sv
frame_buffer.sv
vga_sync.sv
vga_display.sv
top_ov7670.sv
tb_top_ov7670_assert.sv
tb_top_ov7670.sv

// File: Bender.yml
package:
  name: ovcam

sources:
  - ovcam_pkg.sv
  - ov7670_capture.sv
  - frame_buffer.sv
  - vga_sync.sv
  - vga_display.sv
  - top_ov7670.sv
  - target: simulation
    files:
      - tb_top_ov7670_assert.sv
      - tb_top_ov7670.sv

// File: tb_top_ov7670.sv
// testbench for the camera to display top level
// sends the trace frame, then an lfsr frame with freeze high and again with it low
// a checker at the falling edge compares every vga sample with a raster model
// expected colours come from a reference image built with the rgb565 to rgb444 rule
`timescale 1ns/1ps
`default_nettype none

module tb_top_ov7670
  import ovcam_pkg::*;
;

  localparam int frame_clks     = h_total * v_total * clks_per_pxl;
  localparam int cam_frame_clks = 4 * (3 + img_rows * (2 * img_cols + 2));
  localparam int timeout_clks   = 10 * frame_clks + 3 * cam_frame_clks + 400;

  logic     clk;
  logic     arst_n;
  logic     freeze;
  cam_bus_t cam;
  vga_out_t vga;

  rgb565_t trace    [img_pxls];
  rgb565_t lfsr_img [img_pxls];
  rgb444_t ref_img  [img_pxls];

  // raster model state, k counts rising edges since reset release
  int unsigned k;
  int frame_no = -1;
  int img_frame = -10;
  int s;
  int q;
  int col;
  int row;
  int idx;
  bit exp_vis;
  logic prev_hs = 1'b1;
  logic prev_vs = 1'b1;
  int hs_fall = 0;
  int vs_fall = 0;
  int hs_cnt = 0;
  int rst_errs = 0;
  int ras_errs = 0;
  int blank_errs = 0;
  int img_errs = 0;
  int err_total = 0;
  int n_tests = 0;
  int n_failed = 0;
  int cyc;
  logic [31:0] lfsr;

  top_ov7670 dut0 (
    .clk    (clk),
    .arst_n (arst_n),
    .freeze (freeze),
    .cam    (cam),
    .vga    (vga)
  );

  bind top_ov7670 tb_top_ov7670_assert asrt0 (
    .clk    (clk),
    .arst_n (arst_n),
    .cap_wr (cap_wr),
    .vga    (vga)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] st);
    return {st[30:0], st[31] ^ st[21] ^ st[1] ^ st[0]};
  endfunction

  // top nibbles of each field, sensor has red and blue swapped
  function automatic rgb444_t to_buf_word(input rgb565_t p);
    chan_t r_top;
    chan_t g_top;
    chan_t b_top;
    r_top = p[15:12];
    g_top = p[10:7];
    b_top = p[4:1];
    return {b_top, g_top, r_top};
  endfunction

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got,
                         inout int errs);
    if (got !== exp) begin
      $display("ERR t=%0t %s exp %0h got %0h", $time, name, exp, got);
      errs++;
    end
  endtask

  task automatic report_test(input string name, input int errs);
    n_tests++;
    err_total += errs;
    if (errs == 0) begin
      $display("test %-16s ok", name);
    end else begin
      n_failed++;
      $display("test %-16s %0d errors", name, errs);
    end
  endtask

  // one pclk period, 2 clocks low then 2 high, data set with the falling pclk
  task automatic pclk_cycle(input logic vs, input logic hr, input logic [7:0] d);
    @(posedge clk);
    cam <= '{pclk: 1'b0, vsync: vs, href: hr, data: d};
    repeat (2) @(posedge clk);
    cam.pclk <= 1'b1;
    @(posedge clk);
  endtask

  task automatic send_frame(input bit use_lfsr);
    rgb565_t w;
    int r;
    int c;
    int i;
    // vsync pulse, one idle pclk before the first line
    pclk_cycle(1'b1, 1'b0, 8'h00);
    pclk_cycle(1'b1, 1'b0, 8'h00);
    pclk_cycle(1'b0, 1'b0, 8'h00);
    for (r = 0; r < img_rows; r++) begin
      for (c = 0; c < img_cols; c++) begin
        i = r * img_cols + c;
        w = use_lfsr ? lfsr_img[i] : trace[i];
        // frozen buffer keeps the previous image
        if (!freeze) begin
          ref_img[i] = to_buf_word(w);
        end
        pclk_cycle(1'b0, 1'b1, w[15:8]);
        pclk_cycle(1'b0, 1'b1, w[7:0]);
      end
      // line blanking
      repeat (2) pclk_cycle(1'b0, 1'b0, 8'h00);
    end
  endtask

  // compare one full display frame against the reference image
  task automatic check_image(input string name);
    img_errs = 0;
    img_frame = frame_no + 1;
    wait (frame_no == img_frame + 1);
    report_test(name, img_errs);
  endtask

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      k <= 0;
    end else begin
      k <= k + 1;
    end
  end

  // outputs lag the raster by one clock, slot s shows at k = 2s+1 and 2s+2
  always @(negedge clk) begin
    // reset values hold until the first rising edge after release
    if (!arst_n || k == 0) begin
      compare("vga.hsync", 1'b1, vga.hsync, rst_errs);
      compare("vga.vsync", 1'b1, vga.vsync, rst_errs);
      compare("vga.red", 0, vga.red, rst_errs);
      compare("vga.green", 0, vga.green, rst_errs);
      compare("vga.blue", 0, vga.blue, rst_errs);
    end
    if (arst_n && k > 0) begin
      s        = (k - 1) / 2;
      q        = s % (h_total * v_total);
      col      = q % h_total;
      row      = q / h_total;
      frame_no = (k - 1) / frame_clks;
      exp_vis  = (col < h_visible) && (row < v_visible);
      compare("vga.hsync", !(col >= h_visible + h_front && col < h_visible + h_front + h_sync),
              vga.hsync, ras_errs);
      compare("vga.vsync", !(row >= v_visible + v_front && row < v_visible + v_front + v_sync),
              vga.vsync, ras_errs);
      if (!exp_vis) begin
        compare("vga.red", 0, vga.red, blank_errs);
        compare("vga.green", 0, vga.green, blank_errs);
        compare("vga.blue", 0, vga.blue, blank_errs);
      end else if (frame_no == img_frame) begin
        idx = row * img_cols + col;
        compare("vga.red", ref_img[idx][11:8], vga.red, img_errs);
        compare("vga.green", ref_img[idx][7:4], vga.green, img_errs);
        compare("vga.blue", ref_img[idx][3:0], vga.blue, img_errs);
      end
      // pulse widths and periods measured from the edges
      if (prev_hs && !vga.hsync) begin
        hs_fall = k;
        hs_cnt++;
      end
      if (!prev_hs && vga.hsync && hs_fall > 0) begin
        compare("hsync_low_clks", h_sync * clks_per_pxl, k - hs_fall, ras_errs);
      end
      if (prev_vs && !vga.vsync) begin
        if (vs_fall > 0) begin
          compare("vsync_period_clks", frame_clks, k - vs_fall, ras_errs);
          compare("hsync_per_frame", v_total, hs_cnt, ras_errs);
        end
        vs_fall = k;
        hs_cnt  = 0;
      end
      if (!prev_vs && vga.vsync && vs_fall > 0) begin
        compare("vsync_low_clks", v_sync * h_total * clks_per_pxl, k - vs_fall, ras_errs);
      end
      prev_hs = vga.hsync;
      prev_vs = vga.vsync;
    end
  end

  // watchdog
  initial begin
    cyc = 0;
    while (cyc < timeout_clks) begin
      @(posedge clk);
      cyc++;
    end
    $display("timeout, the run did not finish within %0d clocks", timeout_clks);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    arst_n = 1'b0;
    freeze = 1'b0;
    cam    = '0;
    $readmemh("ovcam_trace.txt", trace);
    // second image, 16 lfsr steps per pixel
    lfsr = 32'he018_a159;
    for (int i = 0; i < img_pxls; i++) begin
      for (int b = 0; b < 16; b++) begin
        lfsr = lfsr_next(lfsr);
        lfsr_img[i] = {lfsr_img[i][14:0], lfsr[0]};
      end
    end
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    repeat (4) @(posedge clk);
    report_test("reset", rst_errs);
    send_frame(1'b0);
    check_image("capture");
    @(posedge clk);
    freeze <= 1'b1;
    send_frame(1'b1);
    check_image("freeze_hold");
    @(posedge clk);
    freeze <= 1'b0;
    send_frame(1'b1);
    check_image("freeze_release");
    report_test("raster", ras_errs);
    report_test("blanking", blank_errs);
    report_test("assertions", dut0.asrt0.n_fail);
    $display("summary: %0d tests, %0d failed, %0d errors", n_tests, n_failed, err_total);
    if (err_total == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_top_ov7670_assert.sv
// concurrent checks bound into the camera to display top level
// looks at the capture write strobe and the vga output port
// n_fail counts failed assertions for the testbench summary
`timescale 1ns/1ps
`default_nettype none

module tb_top_ov7670_assert
  import ovcam_pkg::*;
(
  input logic     clk,
  input logic     arst_n,
  input buf_wr_t  cap_wr,
  input vga_out_t vga
);

  int unsigned n_fail = 0;

  // one write per assembled pixel
  a_we_single : assert property (@(posedge clk) disable iff (!arst_n)
    cap_wr.we |=> !cap_wr.we)
    else begin
      $error("capture write strobe high for two clocks");
      n_fail++;
    end

  // no colour during sync
  a_sync_blank : assert property (@(posedge clk) disable iff (!arst_n)
    (!vga.hsync || !vga.vsync) |-> (vga.red == '0 && vga.green == '0 && vga.blue == '0))
    else begin
      $error("colour output not zero while a sync is low");
      n_fail++;
    end

  // 3 slots of 2 clocks
  a_hsync_width : assert property (@(posedge clk) disable iff (!arst_n)
    $fell(vga.hsync) |-> !vga.hsync [*6] ##1 vga.hsync)
    else begin
      $error("hsync pulse not 6 clocks wide");
      n_fail++;
    end

endmodule

`default_nettype wire

// File: top_ov7670.sv
// camera to display top level
// capture writes the frame buffer, the raster reads it back out
// freeze high blocks buffer writes so the last frame stays on screen
// clock comes in directly, no camera configuration is done here
`timescale 1ns/1ps
`default_nettype none

module top_ov7670
  import ovcam_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  logic     freeze,
  input  cam_bus_t cam,
  output vga_out_t vga
);

  buf_wr_t   cap_wr;    // from capture
  buf_wr_t   fb_wr;     // after freeze gating
  img_addr_t rd_addr;
  rgb444_t   rd_data;
  logic      new_pxl;
  vga_pos_t  pos;

  ov7670_capture i_capture (
    .clk    (clk),
    .arst_n (arst_n),
    .cam    (cam),
    .wr     (cap_wr)
  );

  // only the strobe is gated
  assign fb_wr = '{we: cap_wr.we & ~freeze, addr: cap_wr.addr, data: cap_wr.data};

  frame_buffer i_fb (
    .clk     (clk),
    .wr      (fb_wr),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  vga_sync i_sync (
    .clk     (clk),
    .arst_n  (arst_n),
    .new_pxl (new_pxl),
    .pos     (pos)
  );

  vga_display i_display (
    .clk     (clk),
    .arst_n  (arst_n),
    .new_pxl (new_pxl),
    .pos     (pos),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .vga     (vga)
  );

endmodule

`default_nettype wire

// File: vga_display.sv
// display side of the frame buffer
// buffer word r*8+c is shown at column c and row r of the visible area
// the read address is prefetched into a register on new_pxl, so it moves
// together with the raster position and the read data follows one clock later
// syncs and visible are delayed one clock to match, colour is blanked outside
`timescale 1ns/1ps
`default_nettype none

module vga_display
  import ovcam_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  logic      new_pxl,
  input  vga_pos_t  pos,
  output img_addr_t rd_addr,
  input  rgb444_t   rd_data,
  output vga_out_t  vga
);

  logic     last_col;
  ras_cnt_t nxt_col;
  ras_cnt_t nxt_row;
  logic     nxt_vis;
  logic     vis_d;
  logic     hsync_d;
  logic     vsync_d;
  chan_t    red;
  chan_t    green;
  chan_t    blue;

  // position the raster moves to on this new_pxl
  assign last_col = (pos.col == ras_cnt_t'(h_total - 1));
  assign nxt_col  = last_col ? '0 : pos.col + 1'b1;
  always_comb begin
    nxt_row = pos.row;
    if (last_col) begin
      nxt_row = (pos.row == ras_cnt_t'(v_total - 1)) ? '0 : pos.row + 1'b1;
    end
  end
  assign nxt_vis = (nxt_col < h_visible) && (nxt_row < v_visible);

  // reset matches position (0,0), word 0
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_addr <= '0;
    end else if (new_pxl) begin
      // outside the image park on word 0
      rd_addr <= nxt_vis ? img_addr_t'(nxt_row * img_cols + nxt_col) : '0;
    end
  end

  // one clock delay, same as the buffer read
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vis_d   <= 1'b0;
      hsync_d <= 1'b1;
      vsync_d <= 1'b1;
    end else begin
      vis_d   <= pos.visible;
      hsync_d <= pos.hsync;
      vsync_d <= pos.vsync;
    end
  end

  // blanking
  assign red   = vis_d ? rd_data[11:8] : '0;
  assign green = vis_d ? rd_data[7:4]  : '0;
  assign blue  = vis_d ? rd_data[3:0]  : '0;

  assign vga = '{red: red, green: green, blue: blue, hsync: hsync_d, vsync: vsync_d};

endmodule

`default_nettype wire

// File: vga_sync.sv
// raster generator for the miniature vga timing
// new_pxl marks the last clock of each pixel slot
// col and row advance on new_pxl and wrap at the raster totals
// visible and syncs are registered together with the counters
`timescale 1ns/1ps
`default_nettype none

module vga_sync
  import ovcam_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  output logic     new_pxl,
  output vga_pos_t pos
);

  typedef logic [$clog2(clks_per_pxl)-1:0] div_t;

  div_t     clk_cnt;
  ras_cnt_t col;
  ras_cnt_t row;
  ras_cnt_t col_nxt;
  ras_cnt_t row_nxt;
  logic     visible;
  logic     hsync;
  logic     vsync;

  assign new_pxl = (clk_cnt == div_t'(clks_per_pxl - 1));

  // next raster position
  always_comb begin
    col_nxt = col;
    row_nxt = row;
    if (new_pxl) begin
      if (col == ras_cnt_t'(h_total - 1)) begin
        col_nxt = '0;
        if (row == ras_cnt_t'(v_total - 1)) begin
          row_nxt = '0;
        end else begin
          row_nxt = row + 1'b1;
        end
      end else begin
        col_nxt = col + 1'b1;
      end
    end
  end

  // flags decoded from the next position so they line up with col and row
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      clk_cnt <= '0;
      col     <= '0;
      row     <= '0;
      visible <= 1'b0;
      hsync   <= 1'b1;
      vsync   <= 1'b1;
    end else begin
      clk_cnt <= new_pxl ? '0 : clk_cnt + 1'b1;
      col     <= col_nxt;
      row     <= row_nxt;
      visible <= (col_nxt < h_visible) && (row_nxt < v_visible);
      // active low, sync slots sit after the front porch
      hsync   <= !((col_nxt >= h_visible + h_front) &&
                   (col_nxt <  h_visible + h_front + h_sync));
      vsync   <= !((row_nxt >= v_visible + v_front) &&
                   (row_nxt <  v_visible + v_front + v_sync));
    end
  end

  assign pos = '{col: col, row: row, visible: visible, hsync: hsync, vsync: vsync};

endmodule

`default_nettype wire

// File: frame_buffer.sv
// frame buffer between capture and display
// write port from capture, takes effect at the clock edge
// read port for display, data one clock after the address
// contents are undefined until the first frame has been captured
`timescale 1ns/1ps
`default_nettype none

module frame_buffer
  import ovcam_pkg::*;
(
  input  logic      clk,
  input  buf_wr_t   wr,
  input  img_addr_t rd_addr,
  output rgb444_t   rd_data
);

  // one word per image pixel
  rgb444_t mem [img_pxls];

  // capture side
  always_ff @(posedge clk) begin
    if (wr.we) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // display side, registered read
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// File: ov7670_capture.sv
// camera port capture for an ov7670 style sensor in rgb565 mode
// the port is sampled in the system clock domain, pclk is edge detected
// two bytes make one pixel, reduced to rgb444 and written to the frame buffer
// write strobe is one clock wide, address restarts at every vsync rise
`timescale 1ns/1ps
`default_nettype none

module ov7670_capture
  import ovcam_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  cam_bus_t cam,
  output buf_wr_t  wr
);

  cam_bus_t   cam_q;
  logic       pclk_q;
  logic       vsync_q;
  logic       pclk_rise;
  logic       vsync_rise;
  logic       byte_ph;     // 0 waits for high byte, 1 for low byte
  logic [7:0] hi_byte;
  rgb565_t    pxl565;
  rgb444_t    pxl444;
  img_addr_t  addr_cnt;
  logic       wr_we;
  img_addr_t  wr_addr;
  rgb444_t    wr_data;

  // edge detect on the registered samples
  assign pclk_rise  = cam_q.pclk & ~pclk_q;
  assign vsync_rise = cam_q.vsync & ~vsync_q;

  // pixel as it will be once the low byte is in
  assign pxl565 = {hi_byte, cam_q.data};

  // keep top nibble of each field
  always_comb begin
    if (swap_r_b) begin
      // blue field holds red here, red field holds blue
      pxl444 = {pxl565[4:1], pxl565[10:7], pxl565[15:12]};
    end else begin
      pxl444 = {pxl565[15:12], pxl565[10:7], pxl565[4:1]};
    end
  end

  // sample the pins, history for edge detection
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cam_q   <= '0;
      pclk_q  <= 1'b0;
      vsync_q <= 1'b0;
    end else begin
      cam_q   <= cam;
      pclk_q  <= cam_q.pclk;
      vsync_q <= cam_q.vsync;
    end
  end

  // byte pairing, address count and write strobe
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      byte_ph  <= 1'b0;
      addr_cnt <= '0;
      wr_we    <= 1'b0;
    end else begin
      wr_we <= 1'b0;
      if (vsync_rise) begin
        // new frame
        byte_ph  <= 1'b0;
        addr_cnt <= '0;
      end else if (pclk_rise) begin
        if (!cam_q.href) begin
          // blanking bytes, stay aligned on the high byte
          byte_ph <= 1'b0;
        end else if (!byte_ph) begin
          byte_ph <= 1'b1;
        end else begin
          byte_ph <= 1'b0;
          wr_we   <= 1'b1;
          // extra pixels past the image fold back to word 0
          if (addr_cnt == img_addr_t'(img_pxls - 1)) begin
            addr_cnt <= '0;
          end else begin
            addr_cnt <= addr_cnt + 1'b1;
          end
        end
      end
    end
  end

  // payload, only meaningful with the strobe
  always_ff @(posedge clk) begin
    if (pclk_rise && cam_q.href && !byte_ph) begin
      hi_byte <= cam_q.data;
    end
    if (pclk_rise && cam_q.href && byte_ph) begin
      wr_addr <= addr_cnt;
      wr_data <= pxl444;
    end
  end

  assign wr = '{we: wr_we, addr: wr_addr, data: wr_data};

endmodule

`default_nettype wire

// File: ovcam_pkg.sv
// shared sizes, types and bus structs for the camera to display path
// image and raster are scaled down so a frame simulates in a few hundred clocks
// every design file imports this package in its module header
`default_nettype none

package ovcam_pkg;

  // captured image size
  localparam int img_cols    = 8;
  localparam int img_rows    = 6;
  localparam int img_pxls    = img_cols * img_rows;
  localparam int nb_img_pxls = 6;

  // horizontal raster, in pixel slots
  localparam int h_visible = img_cols;
  localparam int h_front   = 2;
  localparam int h_sync    = 3;
  localparam int h_back    = 3;
  localparam int h_total   = h_visible + h_front + h_sync + h_back;

  // vertical raster, in lines
  localparam int v_visible = img_rows;
  localparam int v_front   = 1;
  localparam int v_sync    = 2;
  localparam int v_back    = 1;
  localparam int v_total   = v_visible + v_front + v_sync + v_back;

  // system clocks per pixel slot
  localparam int clks_per_pxl = 2;

  // sensor sends red and blue swapped
  localparam bit swap_r_b = 1'b1;

  typedef logic [nb_img_pxls-1:0] img_addr_t;
  typedef logic [15:0]            rgb565_t;
  typedef logic [11:0]            rgb444_t;   // red in [11:8], blue in [3:0]
  typedef logic [3:0]             chan_t;
  typedef logic [3:0]             ras_cnt_t;  // raster column or row

  // parallel camera port as seen on the pins
  typedef struct packed {
    logic       pclk;
    logic       vsync;
    logic       href;
    logic [7:0] data;
  } cam_bus_t;

  // raster position with syncs, active low
  typedef struct packed {
    ras_cnt_t col;
    ras_cnt_t row;
    logic     visible;
    logic     hsync;
    logic     vsync;
  } vga_pos_t;

  typedef struct packed {
    chan_t red;
    chan_t green;
    chan_t blue;
    logic  hsync;
    logic  vsync;
  } vga_out_t;

  // frame buffer write port
  typedef struct packed {
    logic      we;
    img_addr_t addr;
    rgb444_t   data;
  } buf_wr_t;

endpackage

`default_nettype wire
